// File: fir_accel.f
logic/fir_accel_pkg.sv
logic/coeff_bank.sv
logic/coeff_arbiter.sv
logic/ahb_slave_port.sv
logic/fir_datapath.sv
logic/fir_accel.sv
testbench/fir_accel_asserts.sv
testbench/fir_accel_tb.sv

// File: Bender.yml
package:
  name: fir_accel

sources:
  - logic/fir_accel_pkg.sv
  - logic/coeff_bank.sv
  - logic/coeff_arbiter.sv
  - logic/ahb_slave_port.sv
  - logic/fir_datapath.sv
  - logic/fir_accel.sv
  - target: test
    files:
      - testbench/fir_accel_asserts.sv
      - testbench/fir_accel_tb.sv

// File: testbench/fir_accel_tb.sv
// ********************
// Testbench for the FIR accelerator, drives the AHB-Lite slave pins
// Reference model in fir_ref, reads compared by a separate process
// ********************
`timescale 1ns/1ps

module fir_accel_tb import fir_accel_pkg::*; ();

  // Watchdog budget
  localparam int N_XFER     = 220;
  localparam int N_SAMPLES  = 20;
  localparam int CLK_NS     = 4;
  localparam int TIMEOUT_NS = (N_XFER + 40 * N_SAMPLES) * CLK_NS * 2;

  logic              tb_clk;
  logic              rst;
  logic              hsel;
  htrans_e           htrans;
  logic [ADDR_W-1:0] haddr;
  hsize_e            hsize;
  logic              hwrite;
  logic [DATA_W-1:0] hwdata;
  logic [DATA_W-1:0] hrdata;
  logic              hresp;

  // Model state
  logic [DATA_W-1:0] model_coef [NUM_TAPS];
  logic [DATA_W-1:0] model_hist [NUM_TAPS];
  int                err_count;

  // Handoff to the compare process
  event              read_done;
  string             rd_name;
  logic [DATA_W-1:0] rd_data;
  logic [DATA_W-1:0] rd_exp;
  logic              rd_resp;
  logic              rd_exp_resp;
  logic              rd_chk;

  fir_accel fir_accel_i (.*);

  always #(CLK_NS / 2) tb_clk = ~tb_clk;

  // ********************
  // Reference and checks
  // ********************
  // Returns {overflow, result}, shifts the model history
  function automatic logic [DATA_W:0] fir_ref(input logic [DATA_W-1:0] s);
    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] scaled;
    for (int k = NUM_TAPS - 1; k > 0; k--) begin
      model_hist[k] = model_hist[k-1];
    end
    model_hist[0] = s;
    acc = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      acc = acc + ACC_W'(model_coef[k]) * ACC_W'(model_hist[k]);
    end
    scaled = acc >> Q_FRAC_BITS;
    // Anything above 16 bits saturates
    if (scaled > ACC_W'(16'hFFFF)) begin
      return {1'b1, 16'hFFFF};
    end
    return {1'b0, scaled[DATA_W-1:0]};
  endfunction

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_resp(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH time=%0t hresp(%s) got=%b exp=%b", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Compare process
  always @(read_done) begin
    check_resp(rd_name, rd_resp, rd_exp_resp);
    if (rd_chk) begin
      check_data(rd_name, rd_data, rd_exp);
    end
  end

  // ********************
  // Bus tasks
  // ********************
  task automatic report(input string name, input logic chk, input logic [DATA_W-1:0] exp,
                        input logic exp_resp);
    rd_name     = name;
    rd_data     = hrdata;
    rd_resp     = hresp;
    rd_exp      = exp;
    rd_exp_resp = exp_resp;
    rd_chk      = chk;
    -> read_done;
  endtask

  // Single transfer, address phase then data phase, sampled mid data phase
  task automatic xfer(input logic wr, input logic [ADDR_W-1:0] addr, input hsize_e size,
                      input logic [DATA_W-1:0] wdata, input logic exp_resp,
                      input logic chk, input logic [DATA_W-1:0] exp, input string name,
                      output logic [DATA_W-1:0] rdata);
    @(posedge tb_clk);
    hsel   <= 1'b1;
    htrans <= NONSEQ;
    haddr  <= addr;
    hsize  <= size;
    hwrite <= wr;
    @(posedge tb_clk);
    hwdata <= wdata;
    hsel   <= 1'b0;
    htrans <= IDLE;
    @(negedge tb_clk);
    rdata = hrdata;
    report(name, chk & ~wr, exp, exp_resp);
  endtask

  // Four halfword coefficient reads, back to back
  task automatic coef_burst();
    for (int i = 0; i <= NUM_TAPS; i++) begin
      @(posedge tb_clk);
      if (i < NUM_TAPS) begin
        hsel   <= 1'b1;
        htrans <= (i == 0) ? NONSEQ : SEQ;
        haddr  <= ADDR_W'(ADDR_COEF_START + 2 * i);
        hsize  <= SIZE_HALF;
        hwrite <= 1'b0;
      end else begin
        hsel   <= 1'b0;
        htrans <= IDLE;
      end
      if (i > 0) begin
        @(negedge tb_clk);
        report($sformatf("coef%0d", i - 1), 1'b1, model_coef[i-1], 1'b0);
      end
    end
  endtask

  task automatic wait_idle();
    logic [DATA_W-1:0] st;
    do begin
      xfer(1'b0, ADDR_STATUS, SIZE_HALF, '0, 1'b0, 1'b0, '0, "status", st);
    end while (st[STATUS_BUSY_BIT]);
  endtask

  task automatic check_result(input logic [DATA_W:0] exp);
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] st_exp;
    st_exp                 = '0;
    st_exp[STATUS_ERR_BIT] = exp[DATA_W];
    xfer(1'b0, ADDR_RESULT, SIZE_HALF, '0, 1'b0, 1'b1, exp[DATA_W-1:0], "result", rd);
    xfer(1'b0, ADDR_STATUS, SIZE_HALF, '0, 1'b0, 1'b1, st_exp, "status", rd);
  endtask

  task automatic write_coef(input int idx, input logic [DATA_W-1:0] val);
    logic [DATA_W-1:0] rd;
    xfer(1'b1, ADDR_W'(ADDR_COEF_START + 2 * idx), SIZE_HALF, val, 1'b0, 1'b0, '0,
         "coef write", rd);
    model_coef[idx] = val;
  endtask

  task automatic read_coefs();
    logic [DATA_W-1:0] rd;
    for (int i = 0; i < NUM_TAPS; i++) begin
      xfer(1'b0, ADDR_W'(ADDR_COEF_START + 2 * i), SIZE_HALF, '0, 1'b0, 1'b1,
           model_coef[i], $sformatf("coef%0d", i), rd);
    end
  endtask

  task automatic run_sample(input logic [DATA_W-1:0] s);
    logic [DATA_W-1:0] rd;
    logic [DATA_W:0]   exp;
    xfer(1'b1, ADDR_SAMPLE, SIZE_HALF, s, 1'b0, 1'b0, '0, "sample write", rd);
    exp = fir_ref(s);
    wait_idle();
    check_result(exp);
  endtask

  // ********************
  // Stimulus
  // ********************
  initial begin
    logic [DATA_W-1:0] rd;
    logic [DATA_W:0]   exp;
    logic [DATA_W-1:0] smp;
    void'($urandom(32'he6fa_90fb));
    tb_clk    = 1'b0;
    rst       = 1'b1;
    hsel      = 1'b0;
    htrans    = IDLE;
    haddr     = '0;
    hsize     = SIZE_HALF;
    hwrite    = 1'b0;
    hwdata    = '0;
    err_count = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      model_coef[k] = '0;
      model_hist[k] = '0;
    end
    repeat (3) @(posedge tb_clk);
    rst <= 1'b0;

    // Reset values
    check_result({1'b0, 16'h0000});
    read_coefs();

    // Byte lane merging
    write_coef(0, 16'h1234);
    xfer(1'b1, 4'd7, SIZE_BYTE, 16'hAB00, 1'b0, 1'b0, '0, "coef byte", rd);
    model_coef[0] = 16'hAB34;
    xfer(1'b1, 4'd8, SIZE_BYTE, 16'h00CD, 1'b0, 1'b0, '0, "coef byte", rd);
    xfer(1'b1, 4'd9, SIZE_BYTE, 16'hEF00, 1'b0, 1'b0, '0, "coef byte", rd);
    model_coef[1] = 16'hEFCD;
    read_coefs();

    // Random coefficient sets and samples
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        write_coef(i, DATA_W'($urandom));
      end
      for (int n = 0; n < 4; n++) begin
        run_sample(DATA_W'($urandom));
      end
    end

    // Saturation, unity gain on every tap
    for (int i = 0; i < NUM_TAPS; i++) begin
      write_coef(i, 16'h8000);
    end
    for (int n = 0; n < 4; n++) begin
      run_sample(16'hFFFF);
    end

    // Error responses
    xfer(1'b1, ADDR_STATUS, SIZE_HALF, 16'h0003, 1'b1, 1'b0, '0, "status write", rd);
    xfer(1'b1, ADDR_RESULT, SIZE_HALF, 16'h1111, 1'b1, 1'b0, '0, "result write", rd);
    xfer(1'b0, 4'd14, SIZE_HALF, '0, 1'b1, 1'b0, '0, "addr14 read", rd);
    xfer(1'b1, 4'd14, SIZE_HALF, 16'h5555, 1'b1, 1'b0, '0, "addr14 write", rd);
    xfer(1'b0, 4'd15, SIZE_BYTE, '0, 1'b1, 1'b0, '0, "addr15 read", rd);
    xfer(1'b0, 4'd7, SIZE_HALF, '0, 1'b1, 1'b0, '0, "odd half read", rd);
    xfer(1'b1, 4'd9, SIZE_HALF, 16'h7777, 1'b1, 1'b0, '0, "odd half write", rd);
    check_result({1'b1, 16'hFFFF});
    read_coefs();

    // Second sample while busy is dropped
    for (int i = 0; i < NUM_TAPS; i++) begin
      write_coef(i, DATA_W'($urandom));
    end
    xfer(1'b1, ADDR_SAMPLE, SIZE_HALF, 16'h4321, 1'b0, 1'b0, '0, "sample write", rd);
    exp = fir_ref(16'h4321);
    xfer(1'b1, ADDR_SAMPLE, SIZE_HALF, 16'h9999, 1'b1, 1'b0, '0, "busy sample", rd);
    wait_idle();
    check_result(exp);

    // Coefficient reads racing the filter fetches
    for (int n = 0; n < 3; n++) begin
      smp = DATA_W'($urandom);
      xfer(1'b1, ADDR_SAMPLE, SIZE_HALF, smp, 1'b0, 1'b0, '0, "sample write", rd);
      exp = fir_ref(smp);
      coef_burst();
      coef_burst();
      wait_idle();
      check_result(exp);
    end

    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $fatal(1);
  end

endmodule

// File: testbench/fir_accel_asserts.sv
// ********************
// Bus response and arbitration properties, bound to the top level
// ********************
`timescale 1ns/1ps

module fir_accel_asserts import fir_accel_pkg::*; (
  input logic                 tb_clk,
  input logic                 rst,
  input logic                 hsel,
  input htrans_e              htrans,
  input logic                 hresp,
  input logic                 coef_bus_req,
  input logic                 coef_fir_valid,
  input logic [TAP_IDX_W-1:0] coef_fir_idx,
  input logic                 coef_fir_rvalid,
  input logic                 sample_valid,
  input logic                 sample_ready,
  input fir_state_e           state
);

  // Error pulse only in a data phase
  hresp_phase: assert property (@(posedge tb_clk) disable iff (rst)
    hresp |-> $past(hsel && (htrans == NONSEQ || htrans == SEQ)))
    else $error("hresp without a preceding address phase");

  // Bus has priority, a stalled fetch keeps its request steady
  bus_priority: assert property (@(posedge tb_clk) disable iff (rst)
    (coef_fir_valid && coef_bus_req) |=> (coef_fir_valid && $stable(coef_fir_idx)))
    else $error("filter fetch dropped or changed while the bus held the bank");

  // Read data tag only lands while the datapath walks the taps
  rvalid_follows: assert property (@(posedge tb_clk) disable iff (rst)
    coef_fir_rvalid |-> (state == FIR_FETCH || state == FIR_ACCUM))
    else $error("coef_fir_rvalid outside a tap walk");

  // Accepted sample starts the tap walk
  sample_start: assert property (@(posedge tb_clk) disable iff (rst)
    (sample_valid && sample_ready) |=> (state == FIR_FETCH && !sample_ready))
    else $error("accepted sample did not start the filter");

endmodule

bind fir_accel fir_accel_asserts asserts_i (
  .tb_clk          (tb_clk),
  .rst             (rst),
  .hsel            (hsel),
  .htrans          (htrans),
  .hresp           (hresp),
  .coef_bus_req    (coef_bus_req),
  .coef_fir_valid  (coef_fir_valid),
  .coef_fir_idx    (coef_fir_idx),
  .coef_fir_rvalid (coef_fir_rvalid),
  .sample_valid    (sample_valid),
  .sample_ready    (sample_ready),
  .state           (datapath_i.state)
);

// File: logic/fir_accel.sv
// ********************
// FIR accelerator top, AHB-Lite slave pins only
// Slave and datapath share the coefficient bank through the arbiter
// ********************
`timescale 1ns/1ps

module fir_accel import fir_accel_pkg::*; (
  input  logic              tb_clk,
  input  logic              rst,
  input  logic              hsel,
  input  htrans_e           htrans,
  input  logic [ADDR_W-1:0] haddr,
  input  hsize_e            hsize,
  input  logic              hwrite,
  input  logic [DATA_W-1:0] hwdata,
  output logic [DATA_W-1:0] hrdata,
  output logic              hresp
);

  // Bus side of the arbiter
  logic                 coef_bus_req;
  logic                 coef_bus_write;
  logic [TAP_IDX_W-1:0] coef_bus_idx;
  logic [1:0]           coef_bus_be;
  logic [DATA_W-1:0]    coef_bus_wdata;
  // Filter side of the arbiter
  logic                 coef_fir_valid;
  logic [TAP_IDX_W-1:0] coef_fir_idx;
  logic                 coef_fir_ready;
  logic                 coef_fir_rvalid;
  // Bank port
  logic                 bank_we;
  logic [TAP_IDX_W-1:0] bank_idx;
  logic [1:0]           bank_be;
  logic [DATA_W-1:0]    bank_wdata;
  logic [DATA_W-1:0]    bank_rdata;
  // Sample handshake and result
  logic                 sample_valid;
  logic [DATA_W-1:0]    sample_data;
  logic                 sample_ready;
  logic [DATA_W-1:0]    result;
  logic                 overflow;

  ahb_slave_port slave_i (
    .tb_clk         (tb_clk),
    .rst            (rst),
    .hsel           (hsel),
    .htrans         (htrans),
    .haddr          (haddr),
    .hsize          (hsize),
    .hwrite         (hwrite),
    .hwdata         (hwdata),
    .hrdata         (hrdata),
    .hresp          (hresp),
    .coef_bus_req   (coef_bus_req),
    .coef_bus_write (coef_bus_write),
    .coef_bus_idx   (coef_bus_idx),
    .coef_bus_be    (coef_bus_be),
    .coef_bus_wdata (coef_bus_wdata),
    .bank_rdata     (bank_rdata),
    .sample_valid   (sample_valid),
    .sample_data    (sample_data),
    .sample_ready   (sample_ready),
    .result         (result),
    .overflow       (overflow)
  );

  coeff_arbiter arbiter_i (
    .tb_clk          (tb_clk),
    .rst             (rst),
    .coef_bus_req    (coef_bus_req),
    .coef_bus_write  (coef_bus_write),
    .coef_bus_idx    (coef_bus_idx),
    .coef_bus_wdata  (coef_bus_wdata),
    .coef_bus_be     (coef_bus_be),
    .coef_fir_valid  (coef_fir_valid),
    .coef_fir_idx    (coef_fir_idx),
    .coef_fir_ready  (coef_fir_ready),
    .coef_fir_rvalid (coef_fir_rvalid),
    .bank_we         (bank_we),
    .bank_idx        (bank_idx),
    .bank_be         (bank_be),
    .bank_wdata      (bank_wdata)
  );

  coeff_bank bank_i (
    .tb_clk (tb_clk),
    .rst    (rst),
    .we     (bank_we),
    .idx    (bank_idx),
    .be     (bank_be),
    .wdata  (bank_wdata),
    .rdata  (bank_rdata)
  );

  fir_datapath datapath_i (
    .tb_clk          (tb_clk),
    .rst             (rst),
    .sample_valid    (sample_valid),
    .sample_data     (sample_data),
    .sample_ready    (sample_ready),
    .coef_fir_valid  (coef_fir_valid),
    .coef_fir_idx    (coef_fir_idx),
    .coef_fir_ready  (coef_fir_ready),
    .coef_fir_rvalid (coef_fir_rvalid),
    .bank_rdata      (bank_rdata),
    .result          (result),
    .overflow        (overflow)
  );

endmodule

// File: logic/fir_datapath.sv
// ********************
// Four-tap FIR datapath, unsigned Q1.15 coefficients
// Takes one sample, walks the taps through the bank, saturates the result
// ********************
`timescale 1ns/1ps

module fir_datapath import fir_accel_pkg::*; (
  input  logic                 tb_clk,
  input  logic                 rst,
  input  logic                 sample_valid,
  input  logic [DATA_W-1:0]    sample_data,
  output logic                 sample_ready,
  output logic                 coef_fir_valid,
  output logic [TAP_IDX_W-1:0] coef_fir_idx,
  input  logic                 coef_fir_ready,
  input  logic                 coef_fir_rvalid,
  input  logic [DATA_W-1:0]    bank_rdata,
  output logic [DATA_W-1:0]    result,
  output logic                 overflow
);

  fir_state_e           state;
  fir_state_e           state_next;
  // hist[k] is the sample from k writes ago
  logic [DATA_W-1:0]    hist [NUM_TAPS];
  logic [TAP_IDX_W-1:0] fetch_tap;
  logic [TAP_IDX_W-1:0] acc_tap;
  logic [ACC_W-1:0]     acc;
  logic [2*DATA_W-1:0]  product;
  logic [ACC_W-1:0]     scaled;
  logic                 sample_take;
  logic                 fetch_take;

  assign sample_ready   = (state == FIR_IDLE);
  assign sample_take    = sample_valid & sample_ready;
  // Fetch requests held steady until the arbiter lets one through
  assign coef_fir_valid = (state == FIR_FETCH);
  assign coef_fir_idx   = fetch_tap;
  assign fetch_take     = coef_fir_valid & coef_fir_ready;

  // Coefficient returns pair with the matching history slot
  assign product = bank_rdata * hist[acc_tap];
  assign scaled  = acc >> Q_FRAC_BITS;

  // ********************
  // FSM
  // ********************
  always_comb begin
    state_next = state;
    case (state)
      FIR_IDLE: begin
        if (sample_take) begin
          state_next = FIR_FETCH;
        end
      end
      // Last tap issued, wait for its data
      FIR_FETCH: begin
        if (fetch_take && fetch_tap == TAP_IDX_W'(NUM_TAPS - 1)) begin
          state_next = FIR_ACCUM;
        end
      end
      FIR_ACCUM: begin
        if (coef_fir_rvalid) begin
          state_next = FIR_DONE;
        end
      end
      default: state_next = FIR_IDLE;
    endcase
  end

  always_ff @(posedge tb_clk) begin
    if (rst) begin
      state     <= FIR_IDLE;
      fetch_tap <= '0;
      acc_tap   <= '0;
      result    <= '0;
      overflow  <= 1'b0;
      for (int k = 0; k < NUM_TAPS; k++) begin
        hist[k] <= '0;
      end
    end else begin
      state <= state_next;
      // New sample shifts the history and clears the old flag
      if (sample_take) begin
        hist[0] <= sample_data;
        for (int k = 1; k < NUM_TAPS; k++) begin
          hist[k] <= hist[k-1];
        end
        fetch_tap <= '0;
        acc_tap   <= '0;
        overflow  <= 1'b0;
      end
      if (fetch_take) begin
        fetch_tap <= fetch_tap + 1'b1;
      end
      if (coef_fir_rvalid) begin
        acc_tap <= acc_tap + 1'b1;
      end
      // Saturate anything past 16 bits
      if (state == FIR_DONE) begin
        if (|scaled[ACC_W-1:DATA_W]) begin
          result   <= '1;
          overflow <= 1'b1;
        end else begin
          result <= scaled[DATA_W-1:0];
        end
      end
    end
  end

  // Accumulator, restarted by every sample
  always_ff @(posedge tb_clk) begin
    if (sample_take) begin
      acc <= '0;
    end else if (coef_fir_rvalid) begin
      acc <= acc + ACC_W'(product);
    end
  end

endmodule

// File: logic/ahb_slave_port.sv
// ********************
// AHB-Lite slave for the FIR register map, no wait states
// Address phase is decoded and registered, reply comes in the data phase
// ********************
`timescale 1ns/1ps

module ahb_slave_port import fir_accel_pkg::*; (
  input  logic                 tb_clk,
  input  logic                 rst,
  input  logic                 hsel,
  input  htrans_e              htrans,
  input  logic [ADDR_W-1:0]    haddr,
  input  hsize_e               hsize,
  input  logic                 hwrite,
  input  logic [DATA_W-1:0]    hwdata,
  output logic [DATA_W-1:0]    hrdata,
  output logic                 hresp,
  output logic                 coef_bus_req,
  output logic                 coef_bus_write,
  output logic [TAP_IDX_W-1:0] coef_bus_idx,
  output logic [1:0]           coef_bus_be,
  output logic [DATA_W-1:0]    coef_bus_wdata,
  input  logic [DATA_W-1:0]    bank_rdata,
  output logic                 sample_valid,
  output logic [DATA_W-1:0]    sample_data,
  input  logic                 sample_ready,
  input  logic [DATA_W-1:0]    result,
  input  logic                 overflow
);

  // Address phase
  logic                 a_valid;
  reg_sel_e             a_sel;
  logic [ADDR_W-1:0]    a_off;
  logic [TAP_IDX_W-1:0] a_idx;
  logic [1:0]           a_be;
  logic                 a_err;
  logic                 a_launch;
  logic                 rd_req;
  // Data phase
  logic                 ph_valid;
  logic                 ph_write;
  reg_sel_e             ph_sel;
  logic                 ph_err;
  logic [TAP_IDX_W-1:0] ph_idx;
  logic [1:0]           ph_be;
  logic                 ph_launch;
  logic                 ph_fwd;
  // Coefficient write held back by a colliding read
  logic                 pend_valid;
  logic [TAP_IDX_W-1:0] pend_idx;
  logic [1:0]           pend_be;
  logic [DATA_W-1:0]    pend_wdata;
  logic                 wr_now;
  logic                 wr_go;
  logic [TAP_IDX_W-1:0] wr_idx;
  // Registers and read mux
  logic [DATA_W-1:0]    sample_q;
  logic [DATA_W-1:0]    coef_rd;
  logic [DATA_W-1:0]    status_word;

  // ********************
  // Address phase decode
  // ********************
  assign a_valid = hsel && (htrans == NONSEQ || htrans == SEQ);
  assign a_off   = haddr - ADDR_COEF_START;
  assign a_idx   = a_off[TAP_IDX_W:1];
  // Odd byte rides on the upper lane
  assign a_be    = (hsize == SIZE_HALF) ? 2'b11 : (haddr[0] ? 2'b10 : 2'b01);

  always_comb begin
    if (haddr[ADDR_W-1:1] == ADDR_STATUS[ADDR_W-1:1]) begin
      a_sel = REG_STATUS;
    end else if (haddr[ADDR_W-1:1] == ADDR_RESULT[ADDR_W-1:1]) begin
      a_sel = REG_RESULT;
    end else if (haddr[ADDR_W-1:1] == ADDR_SAMPLE[ADDR_W-1:1]) begin
      a_sel = REG_SAMPLE;
    end else if (haddr >= ADDR_COEF_START && haddr <= ADDR_COEF_END) begin
      a_sel = REG_COEFF;
    end else begin
      a_sel = REG_NONE;
    end
  end

  always_comb begin
    a_err = 1'b0;
    // Unmapped, 14 and 15
    if (a_sel == REG_NONE) begin
      a_err = 1'b1;
    end
    // Misaligned halfword
    if (hsize == SIZE_HALF && haddr[0]) begin
      a_err = 1'b1;
    end
    // Read-only registers
    if (hwrite && (a_sel == REG_STATUS || a_sel == REG_RESULT)) begin
      a_err = 1'b1;
    end
    // Filter busy, or a launch still sitting in its data phase
    if (hwrite && a_sel == REG_SAMPLE && (!sample_ready || ph_launch)) begin
      a_err = 1'b1;
    end
  end

  // Only a low-byte touch starts the filter
  assign a_launch = hwrite && a_sel == REG_SAMPLE && a_be[0] && !a_err;
  assign rd_req   = a_valid && !hwrite && a_sel == REG_COEFF && !a_err;

  always_ff @(posedge tb_clk) begin
    if (rst) begin
      ph_valid  <= 1'b0;
      ph_write  <= 1'b0;
      ph_sel    <= REG_NONE;
      ph_err    <= 1'b0;
      ph_launch <= 1'b0;
      ph_fwd    <= 1'b0;
    end else begin
      ph_valid  <= a_valid;
      ph_write  <= hwrite;
      ph_sel    <= a_sel;
      ph_err    <= a_valid & a_err;
      ph_launch <= a_valid & a_launch;
      // Read of a coefficient whose write has not reached the bank yet
      ph_fwd    <= rd_req & (pend_valid | wr_now) & (wr_idx == a_idx);
    end
  end

  always_ff @(posedge tb_clk) begin
    ph_idx <= a_idx;
    ph_be  <= a_be;
  end

  // ********************
  // Coefficient port
  // ********************
  // Write data only exists in the data phase, reads go out in the address phase
  assign wr_now = ph_valid && ph_write && ph_sel == REG_COEFF && !ph_err;
  assign wr_go  = (pend_valid | wr_now) & ~rd_req;
  assign wr_idx = pend_valid ? pend_idx : ph_idx;

  assign coef_bus_req   = rd_req | wr_go;
  assign coef_bus_write = ~rd_req;
  assign coef_bus_idx   = rd_req ? a_idx : wr_idx;
  assign coef_bus_be    = pend_valid ? pend_be : ph_be;
  assign coef_bus_wdata = pend_valid ? pend_wdata : hwdata;

  // Park the write for one or more cycles while reads hold the port
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      pend_valid <= 1'b0;
    end else if (wr_now && rd_req) begin
      pend_valid <= 1'b1;
    end else if (!rd_req) begin
      pend_valid <= 1'b0;
    end
  end

  always_ff @(posedge tb_clk) begin
    if (wr_now && rd_req) begin
      pend_idx   <= ph_idx;
      pend_be    <= ph_be;
      pend_wdata <= hwdata;
    end
  end

  // Bank data with the parked lanes laid over it
  assign coef_rd = {(ph_fwd && pend_be[1]) ? pend_wdata[DATA_W-1:8] : bank_rdata[DATA_W-1:8],
                    (ph_fwd && pend_be[0]) ? pend_wdata[7:0] : bank_rdata[7:0]};

  // ********************
  // Sample register
  // ********************
  assign sample_data  = {ph_be[1] ? hwdata[DATA_W-1:8] : sample_q[DATA_W-1:8],
                         ph_be[0] ? hwdata[7:0] : sample_q[7:0]};
  assign sample_valid = ph_launch;

  always_ff @(posedge tb_clk) begin
    if (rst) begin
      sample_q <= '0;
    end else if (ph_valid && ph_write && ph_sel == REG_SAMPLE && !ph_err) begin
      sample_q <= sample_data;
    end
  end

  // ********************
  // Data phase reply
  // ********************
  always_comb begin
    status_word                  = '0;
    status_word[STATUS_BUSY_BIT] = ~sample_ready;
    status_word[STATUS_ERR_BIT]  = overflow;
  end

  always_comb begin
    hrdata = '0;
    if (ph_valid && !ph_write && !ph_err) begin
      case (ph_sel)
        REG_STATUS: hrdata = status_word;
        REG_RESULT: hrdata = result;
        REG_SAMPLE: hrdata = sample_q;
        REG_COEFF:  hrdata = coef_rd;
        default:    hrdata = '0;
      endcase
    end
  end

  // One-cycle error pulse
  assign hresp = ph_valid & ph_err;

endmodule

// File: logic/coeff_arbiter.sv
// ********************
// Fixed-priority access to the coefficient bank
// Bus requester always wins, the filter waits on coef_fir_ready
// ********************
`timescale 1ns/1ps

module coeff_arbiter import fir_accel_pkg::*; (
  input  logic                 tb_clk,
  input  logic                 rst,
  input  logic                 coef_bus_req,
  input  logic                 coef_bus_write,
  input  logic [TAP_IDX_W-1:0] coef_bus_idx,
  input  logic [DATA_W-1:0]    coef_bus_wdata,
  input  logic [1:0]           coef_bus_be,
  input  logic                 coef_fir_valid,
  input  logic [TAP_IDX_W-1:0] coef_fir_idx,
  output logic                 coef_fir_ready,
  output logic                 coef_fir_rvalid,
  output logic                 bank_we,
  output logic [TAP_IDX_W-1:0] bank_idx,
  output logic [1:0]           bank_be,
  output logic [DATA_W-1:0]    bank_wdata
);

  logic fir_grant;

  // Filter only gets the bank when the bus is quiet
  assign coef_fir_ready = ~coef_bus_req;
  assign fir_grant      = coef_fir_valid & coef_fir_ready;

  // Steer the winner onto the bank port
  assign bank_idx   = coef_bus_req ? coef_bus_idx : coef_fir_idx;
  assign bank_we    = coef_bus_req & coef_bus_write;
  // No lanes without a write
  assign bank_be    = bank_we ? coef_bus_be : 2'b00;
  assign bank_wdata = coef_bus_wdata;

  // Owner tag for the next read cycle
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      coef_fir_rvalid <= 1'b0;
    end else begin
      coef_fir_rvalid <= fir_grant;
    end
  end

endmodule

// File: logic/coeff_bank.sv
// ********************
// Four coefficient registers with byte enables
// Single port, registered read data one cycle after the access
// ********************
`timescale 1ns/1ps

module coeff_bank import fir_accel_pkg::*; (
  input  logic                 tb_clk,
  input  logic                 rst,
  input  logic                 we,
  input  logic [TAP_IDX_W-1:0] idx,
  input  logic [1:0]           be,
  input  logic [DATA_W-1:0]    wdata,
  output logic [DATA_W-1:0]    rdata
);

  // Coefficient storage, F0 at index 0
  logic [DATA_W-1:0] coef_q [NUM_TAPS];

  // Write port
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        coef_q[i] <= '0;
      end
    end else if (we) begin
      // Low lane
      if (be[0]) begin
        coef_q[idx][7:0] <= wdata[7:0];
      end
      // High lane
      if (be[1]) begin
        coef_q[idx][DATA_W-1:8] <= wdata[DATA_W-1:8];
      end
    end
  end

  // Read port, old value on a same-cycle write
  always_ff @(posedge tb_clk) begin
    rdata <= coef_q[idx];
  end

endmodule

// File: logic/fir_accel_pkg.sv
// ********************
// Shared widths, register map and encodings for the FIR accelerator
// Imported by every RTL module and by the testbench
// ********************
package fir_accel_pkg;

  // ********************
  // Widths
  // ********************
  // Bus word and sample width
  localparam int DATA_W      = 16;
  localparam int ADDR_W      = 4;
  localparam int NUM_TAPS    = 4;
  localparam int TAP_IDX_W   = 2;
  // Unsigned Q1.15, 0x8000 is 1.0
  localparam int Q_FRAC_BITS = 15;
  // Room for four full 32-bit products
  localparam int ACC_W       = 34;

  // ********************
  // Register map
  // ********************
  localparam logic [ADDR_W-1:0] ADDR_STATUS     = 4'd0;
  localparam logic [ADDR_W-1:0] ADDR_RESULT     = 4'd2;
  localparam logic [ADDR_W-1:0] ADDR_SAMPLE     = 4'd4;
  // F0 at 6, F3 ends at 13
  localparam logic [ADDR_W-1:0] ADDR_COEF_START = 4'd6;
  localparam logic [ADDR_W-1:0] ADDR_COEF_END   = 4'd13;

  // Status bits
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_ERR_BIT  = 1;

  // ********************
  // Encodings
  // ********************
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic {
    SIZE_BYTE = 1'b0,
    SIZE_HALF = 1'b1
  } hsize_e;

  // Decoded register target
  typedef enum logic [2:0] {
    REG_STATUS,
    REG_RESULT,
    REG_SAMPLE,
    REG_COEFF,
    REG_NONE
  } reg_sel_e;

  typedef enum logic [1:0] {
    FIR_IDLE,
    FIR_FETCH,
    FIR_ACCUM,
    FIR_DONE
  } fir_state_e;

endpackage
